// ==== source/rtos_pkg.sv ====
// shared types and widths for the kernel core
// imported by every block that decodes commands or keeps task state

package rtos_pkg;

    // --------------------
    // field widths
    // --------------------

    // task id width, up to 16 tasks
    localparam int TSKID_WIDTH  = 4;
    // event flag word width
    localparam int FLGPTN_WIDTH = 8;

    // --------------------
    // command encoding
    // --------------------

    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_WUP_TSK = 3'd1,
        OP_SLP_TSK = 3'd2,
        OP_REL_WAI = 3'd3,
        OP_WAI_FLG = 3'd4,
        OP_SET_FLG = 3'd5,
        OP_CLR_FLG = 3'd6
    } rtos_op_t;

    // and: every pattern bit set, or: any pattern bit set
    typedef enum logic {
        WF_AND = 1'b0,
        WF_OR  = 1'b1
    } rtos_wfmode_t;

    // 3 + 4 + 8 + 1 = 16 bits
    typedef struct packed {
        rtos_op_t                 op;
        logic [TSKID_WIDTH-1:0]   tskid;
        logic [FLGPTN_WIDTH-1:0]  flgptn;
        rtos_wfmode_t             wfmode;
    } rtos_cmd_t;

    // per-task state
    typedef enum logic [1:0] {
        TS_SLEEP  = 2'd0,
        TS_REQRDY = 2'd1,
        TS_READY  = 2'd2,
        TS_WAIFLG = 2'd3
    } task_status_t;

endpackage

// ==== source/rtos_cmd_decode.sv ====
// command decoder, turns one command strobe into per-task strobes
// plus the shared flag-wait fields and event-flag updates

`timescale 1ns/1ps

module rtos_cmd_decode #(
    parameter int TSK_NUM = 4
) (
    input  logic                              cmd_valid,
    input  rtos_pkg::rtos_cmd_t               cmd,

    output logic [TSK_NUM-1:0]                wup_tsk,
    output logic [TSK_NUM-1:0]                slp_tsk,
    output logic [TSK_NUM-1:0]                rel_wai,
    output logic [TSK_NUM-1:0]                wai_flg,
    output logic [rtos_pkg::FLGPTN_WIDTH-1:0] wai_flg_flgptn,
    output rtos_pkg::rtos_wfmode_t            wai_flg_wfmode,

    output logic                              set_flg,
    output logic                              clr_flg,
    output logic [rtos_pkg::FLGPTN_WIDTH-1:0] flg_ptn
);

    import rtos_pkg::*;

    // one-hot task select, ids at or above TSK_NUM never match
    logic [TSK_NUM-1:0] tsk_sel;

    always_comb begin
        for (int i = 0; i < TSK_NUM; i++) begin
            tsk_sel[i] = cmd_valid && (cmd.tskid == TSKID_WIDTH'(i));
        end
    end

    // --------------------
    // task strobes
    // --------------------
    assign wup_tsk = (cmd.op == OP_WUP_TSK) ? tsk_sel : '0;
    assign slp_tsk = (cmd.op == OP_SLP_TSK) ? tsk_sel : '0;
    assign rel_wai = (cmd.op == OP_REL_WAI) ? tsk_sel : '0;
    assign wai_flg = (cmd.op == OP_WAI_FLG) ? tsk_sel : '0;

    // wait fields go to every task, only the strobed one latches them
    assign wai_flg_flgptn = cmd.flgptn;
    assign wai_flg_wfmode = cmd.wfmode;

    // --------------------
    // event flag updates
    // --------------------
    // not tied to a task id
    assign set_flg = cmd_valid && (cmd.op == OP_SET_FLG);
    assign clr_flg = cmd_valid && (cmd.op == OP_CLR_FLG);
    assign flg_ptn = cmd.flgptn;

endmodule

// ==== source/rtos_task.sv ====
// state machine of one task with flag waiting
// talks to the ready queue through registered req/rmv pulses

`timescale 1ns/1ps

module rtos_task #(
    parameter int TSKID = 0
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cke,

    input  logic                              wup_tsk,
    input  logic                              slp_tsk,
    input  logic                              rel_wai,
    input  logic                              wai_flg,
    input  logic                              rdy_tsk,

    input  logic [rtos_pkg::FLGPTN_WIDTH-1:0] wai_flg_flgptn,
    input  rtos_pkg::rtos_wfmode_t            wai_flg_wfmode,
    input  logic [rtos_pkg::FLGPTN_WIDTH-1:0] evtflg_flgptn,

    output rtos_pkg::task_status_t            status,
    output logic                              req_rdq,
    output logic                              rmv_rdq
);

    import rtos_pkg::*;

    // and mode needs every pattern bit, or mode needs any one
    function automatic logic flg_match(
        input logic [FLGPTN_WIDTH-1:0] flag,
        input logic [FLGPTN_WIDTH-1:0] ptn,
        input rtos_wfmode_t            mode
    );
        logic [FLGPTN_WIDTH-1:0] hit;
        hit = flag & ptn;
        if (mode == WF_AND) begin
            return hit == ptn;
        end
        return |hit;
    endfunction

    task_status_t            next_status;
    // wait condition kept for the WAIFLG state
    logic [FLGPTN_WIDTH-1:0] wait_flgptn;
    rtos_wfmode_t            wait_wfmode;
    logic                    was_queued;
    logic                    now_blocked;

    // --------------------
    // next state
    // --------------------
    always_comb begin
        next_status = status;
        // sleep wins over everything including a flag release
        if (slp_tsk) begin
            next_status = TS_SLEEP;
        end else begin
            case (status)
                TS_SLEEP: begin
                    if (wup_tsk) next_status = TS_REQRDY;
                end
                TS_REQRDY: begin
                    // queue has taken the task
                    if (rdy_tsk) next_status = TS_READY;
                end
                TS_READY: begin
                    if (wai_flg) begin
                        // an already satisfied wait goes straight back to the queue
                        if (flg_match(evtflg_flgptn, wai_flg_flgptn, wai_flg_wfmode)) begin
                            next_status = TS_REQRDY;
                        end else begin
                            next_status = TS_WAIFLG;
                        end
                    end
                end
                TS_WAIFLG: begin
                    if (rel_wai) begin
                        next_status = TS_REQRDY;
                    end else if (flg_match(evtflg_flgptn, wait_flgptn, wait_wfmode)) begin
                        next_status = TS_REQRDY;
                    end
                end
                default: next_status = status;
            endcase
        end
    end

    // in the bitmap now or about to be
    assign was_queued  = (status == TS_READY) || (status == TS_REQRDY);
    assign now_blocked = (next_status == TS_SLEEP) || (next_status == TS_WAIFLG);

    always_ff @(posedge clk) begin
        if (reset) begin
            status  <= TS_SLEEP;
            req_rdq <= 1'b0;
            rmv_rdq <= 1'b0;
        end else if (cke) begin
            status  <= next_status;
            // pulse only on entry to REQRDY
            req_rdq <= (next_status == TS_REQRDY) && (status != TS_REQRDY);
            rmv_rdq <= was_queued && now_blocked;
        end
    end

    // wait condition is latched when the wait is accepted
    always_ff @(posedge clk) begin
        if (cke && wai_flg && !slp_tsk && (status == TS_READY)) begin
            wait_flgptn <= wai_flg_flgptn;
            wait_wfmode <= wai_flg_wfmode;
        end
    end

endmodule

// ==== source/rtos_eventflag.sv ====
// shared event-flag word, set ORs bits in and clear ANDs them out
// the flag is only read by waiting tasks, never consumed

`timescale 1ns/1ps

module rtos_eventflag (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cke,

    input  logic                              set_flg,
    input  logic                              clr_flg,
    input  logic [rtos_pkg::FLGPTN_WIDTH-1:0] flg_ptn,

    output logic [rtos_pkg::FLGPTN_WIDTH-1:0] evtflg_flgptn
);

    always_ff @(posedge clk) begin
        if (reset) begin
            evtflg_flgptn <= '0;
        end else if (cke) begin
            if (set_flg) begin
                evtflg_flgptn <= evtflg_flgptn | flg_ptn;
            end else if (clr_flg) begin
                // zero bits in the pattern clear
                evtflg_flgptn <= evtflg_flgptn & flg_ptn;
            end
        end
    end

endmodule

// ==== source/rtos_ready_queue.sv ====
// ready bitmap with lowest-id selection of the running task
// requests are acked by rdy_tsk on the edge that sets the bit

`timescale 1ns/1ps

module rtos_ready_queue #(
    parameter int TSK_NUM = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cke,

    input  logic [TSK_NUM-1:0]               req_rdq,
    input  logic [TSK_NUM-1:0]               rmv_rdq,

    output logic [TSK_NUM-1:0]               rdy_tsk,
    output logic [rtos_pkg::TSKID_WIDTH-1:0] run_tskid,
    output logic                             run_valid
);

    import rtos_pkg::*;

    // one bit per task
    logic [TSK_NUM-1:0] rdq_bitmap;

    // --------------------
    // bitmap update
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rdq_bitmap <= '0;
            rdy_tsk    <= '0;
        end else if (cke) begin
            // removal wins over a request in the same cycle
            rdq_bitmap <= (rdq_bitmap | req_rdq) & ~rmv_rdq;
            rdy_tsk    <= req_rdq & ~rmv_rdq;
        end
    end

    // --------------------
    // priority encoder
    // --------------------
    always_comb begin
        run_tskid = '0;
        // walk down so the lowest set id is left
        for (int i = TSK_NUM - 1; i >= 0; i--) begin
            if (rdq_bitmap[i]) run_tskid = TSKID_WIDTH'(i);
        end
    end

    assign run_valid = |rdq_bitmap;

endmodule

// ==== source/rtos_core.sv ====
// kernel core top level, decoder, task array, event flag and ready queue
// TSK_NUM sets the number of tasks, 1 to 16

`timescale 1ns/1ps

module rtos_core #(
    parameter int TSK_NUM = 4
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        cke,

    input  logic                                        cmd_valid,
    input  rtos_pkg::rtos_cmd_t                         cmd,

    output logic [rtos_pkg::TSKID_WIDTH-1:0]            run_tskid,
    output logic                                        run_valid,
    output logic [rtos_pkg::FLGPTN_WIDTH-1:0]           evtflg_flgptn,
    output rtos_pkg::task_status_t [TSK_NUM-1:0]        task_status
);

    import rtos_pkg::*;

    // decoder to tasks
    logic [TSK_NUM-1:0]      wup_tsk;
    logic [TSK_NUM-1:0]      slp_tsk;
    logic [TSK_NUM-1:0]      rel_wai;
    logic [TSK_NUM-1:0]      wai_flg;
    logic [FLGPTN_WIDTH-1:0] wai_flg_flgptn;
    rtos_wfmode_t            wai_flg_wfmode;

    // decoder to event flag
    logic                    set_flg;
    logic                    clr_flg;
    logic [FLGPTN_WIDTH-1:0] flg_ptn;

    // tasks <-> ready queue
    logic [TSK_NUM-1:0]      req_rdq;
    logic [TSK_NUM-1:0]      rmv_rdq;
    logic [TSK_NUM-1:0]      rdy_tsk;

    rtos_cmd_decode #(
        .TSK_NUM (TSK_NUM)
    ) u_cmd_decode (
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .wup_tsk        (wup_tsk),
        .slp_tsk        (slp_tsk),
        .rel_wai        (rel_wai),
        .wai_flg        (wai_flg),
        .wai_flg_flgptn (wai_flg_flgptn),
        .wai_flg_wfmode (wai_flg_wfmode),
        .set_flg        (set_flg),
        .clr_flg        (clr_flg),
        .flg_ptn        (flg_ptn)
    );

    // --------------------
    // task array, id = generate index
    // --------------------
    for (genvar i = 0; i < TSK_NUM; i++) begin : g_task
        rtos_task #(
            .TSKID (i)
        ) u_task (
            .clk            (clk),
            .reset          (reset),
            .cke            (cke),
            .wup_tsk        (wup_tsk[i]),
            .slp_tsk        (slp_tsk[i]),
            .rel_wai        (rel_wai[i]),
            .wai_flg        (wai_flg[i]),
            .rdy_tsk        (rdy_tsk[i]),
            .wai_flg_flgptn (wai_flg_flgptn),
            .wai_flg_wfmode (wai_flg_wfmode),
            .evtflg_flgptn  (evtflg_flgptn),
            .status         (task_status[i]),
            .req_rdq        (req_rdq[i]),
            .rmv_rdq        (rmv_rdq[i])
        );
    end

    rtos_eventflag u_eventflag (
        .clk           (clk),
        .reset         (reset),
        .cke           (cke),
        .set_flg       (set_flg),
        .clr_flg       (clr_flg),
        .flg_ptn       (flg_ptn),
        .evtflg_flgptn (evtflg_flgptn)
    );

    rtos_ready_queue #(
        .TSK_NUM (TSK_NUM)
    ) u_ready_queue (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .req_rdq   (req_rdq),
        .rmv_rdq   (rmv_rdq),
        .rdy_tsk   (rdy_tsk),
        .run_tskid (run_tskid),
        .run_valid (run_valid)
    );

endmodule

// ==== test/rtos_checker.sv ====
// reference model of tasks, event flag and ready bitmap for the kernel core testbench
// samples on the falling edge, compares ahead of each command and on the final check

`timescale 1ns/1ps

module rtos_checker #(
    parameter int TSK_NUM = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cke,
    input  logic                                 cmd_valid,
    input  rtos_pkg::rtos_cmd_t                  cmd,
    input  logic                                 final_check,
    input  logic [rtos_pkg::TSKID_WIDTH-1:0]     run_tskid,
    input  logic                                 run_valid,
    input  logic [rtos_pkg::FLGPTN_WIDTH-1:0]    evtflg_flgptn,
    input  rtos_pkg::task_status_t [TSK_NUM-1:0] task_status,
    output int                                   mismatch_count,
    output int                                   check_count
);

    import rtos_pkg::*;

    // --------------------
    // model state
    // --------------------
    task_status_t            exp_status [TSK_NUM];
    logic [FLGPTN_WIDTH-1:0] exp_ptn [TSK_NUM];
    rtos_wfmode_t            exp_mode [TSK_NUM];
    logic [FLGPTN_WIDTH-1:0] exp_flag;
    logic [TSK_NUM-1:0]      exp_bitmap;

    // outputs at the previous falling edge, for the stall check
    task_status_t [TSK_NUM-1:0] held_status;
    logic [FLGPTN_WIDTH-1:0]    held_flag;
    logic                       held_valid;
    logic [TSKID_WIDTH-1:0]     held_tskid;
    // cke seen by the rising edge just passed
    logic                       held_cke;

    // and mode: no pattern bit may be missing; or mode: one bit is enough
    function automatic bit wait_satisfied(
        input logic [FLGPTN_WIDTH-1:0] flag,
        input logic [FLGPTN_WIDTH-1:0] ptn,
        input rtos_wfmode_t            mode
    );
        if (mode == WF_AND) begin
            return (ptn & ~flag) == '0;
        end
        return (ptn & flag) != '0;
    endfunction

    // priority equals id, so the lowest ready id runs
    function automatic int lowest_ready(input logic [TSK_NUM-1:0] bits);
        for (int i = 0; i < TSK_NUM; i++) begin
            if (bits[i]) return i;
        end
        return 0;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < TSK_NUM; i++) begin
            exp_status[i] = TS_SLEEP;
            exp_ptn[i]    = '0;
            exp_mode[i]   = WF_AND;
        end
        exp_flag   = '0;
        exp_bitmap = '0;
    endtask

    task automatic set_state(input int id, input task_status_t st);
        exp_status[id] = st;
        // only a ready task sits in the bitmap once settled
        exp_bitmap[id] = (st == TS_READY);
    endtask

    // settled effect of one command
    task automatic apply_command(input rtos_cmd_t c);
        int id;
        bit hit;
        id  = int'(c.tskid);
        hit = id < TSK_NUM;
        case (c.op)
            OP_WUP_TSK: begin
                if (hit && exp_status[id] == TS_SLEEP) set_state(id, TS_READY);
            end
            OP_SLP_TSK: begin
                if (hit) set_state(id, TS_SLEEP);
            end
            OP_REL_WAI: begin
                if (hit && exp_status[id] == TS_WAIFLG) set_state(id, TS_READY);
            end
            OP_WAI_FLG: begin
                if (hit && exp_status[id] == TS_READY) begin
                    exp_ptn[id]  = c.flgptn;
                    exp_mode[id] = c.wfmode;
                    // an already met pattern leaves the task ready
                    if (!wait_satisfied(exp_flag, c.flgptn, c.wfmode)) begin
                        set_state(id, TS_WAIFLG);
                    end
                end
            end
            OP_SET_FLG: begin
                exp_flag = exp_flag | c.flgptn;
                // every waiter whose pattern is now met gets released
                for (int i = 0; i < TSK_NUM; i++) begin
                    if (exp_status[i] == TS_WAIFLG &&
                        wait_satisfied(exp_flag, exp_ptn[i], exp_mode[i])) begin
                        set_state(i, TS_READY);
                    end
                end
            end
            // zero bits clear, nobody is released
            OP_CLR_FLG: exp_flag = exp_flag & c.flgptn;
            default: ;
        endcase
    endtask

    task automatic report(input string what, input logic [31:0] expected,
                          input logic [31:0] observed);
        mismatch_count++;
        $display("Mismatch at %0t: %s expected %0h observed %0h",
                 $time, what, expected, observed);
    endtask

    task automatic compare_outputs();
        check_count++;
        for (int i = 0; i < TSK_NUM; i++) begin
            if (task_status[i] !== exp_status[i]) begin
                report($sformatf("task_status[%0d]", i), exp_status[i], task_status[i]);
            end
        end
        if (evtflg_flgptn !== exp_flag) report("evtflg_flgptn", exp_flag, evtflg_flgptn);
        if (run_valid !== |exp_bitmap) report("run_valid", |exp_bitmap, run_valid);
        // run_tskid has no meaning without a ready task
        if (|exp_bitmap && run_tskid !== TSKID_WIDTH'(lowest_ready(exp_bitmap))) begin
            report("run_tskid", lowest_ready(exp_bitmap), run_tskid);
        end
    endtask

    // a disabled edge must leave every output as it was
    task automatic check_held();
        if (task_status !== held_status) report("task_status in stall", held_status, task_status);
        if (evtflg_flgptn !== held_flag) report("evtflg_flgptn in stall", held_flag, evtflg_flgptn);
        if (run_valid !== held_valid) report("run_valid in stall", held_valid, run_valid);
        if (run_tskid !== held_tskid) report("run_tskid in stall", held_tskid, run_tskid);
    endtask

    always @(negedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            if (held_cke === 1'b0) check_held();
            if (cke && (cmd_valid || final_check)) begin
                // model holds everything up to the previous command
                compare_outputs();
                if (cmd_valid) apply_command(cmd);
            end
        end
        held_status = task_status;
        held_flag   = evtflg_flgptn;
        held_valid  = run_valid;
        held_tskid  = run_tskid;
        held_cke    = cke;
    end

endmodule

// ==== test/rtos_core_tb.sv ====
// testbench for the kernel core, seeded random commands with cke stalls
// the checker module keeps the reference model and counts mismatches

`timescale 1ns/1ps

module rtos_core_tb;

    import rtos_pkg::*;

    localparam int TSK_NUM    = 4;
    localparam int STEP_NUM   = 400;
    // enabled cycles after each command, enough to settle
    localparam int IDLE_NUM   = 4;
    // stalls last at most 3 cycles
    localparam int WAIT_LIMIT = 20;

    logic                       clk;
    logic                       reset;
    logic                       cke;
    logic                       cmd_valid;
    rtos_cmd_t                  cmd;
    logic                       final_check;

    logic [TSKID_WIDTH-1:0]     run_tskid;
    logic                       run_valid;
    logic [FLGPTN_WIDTH-1:0]    evtflg_flgptn;
    task_status_t [TSK_NUM-1:0] task_status;

    int                         mismatch_count;
    int                         check_count;
    int                         timeout_count;
    integer                     seed;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    rtos_core #(
        .TSK_NUM (TSK_NUM)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .cke           (cke),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .run_tskid     (run_tskid),
        .run_valid     (run_valid),
        .evtflg_flgptn (evtflg_flgptn),
        .task_status   (task_status)
    );

    rtos_checker #(
        .TSK_NUM (TSK_NUM)
    ) u_checker (
        .clk            (clk),
        .reset          (reset),
        .cke            (cke),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .final_check    (final_check),
        .run_tskid      (run_tskid),
        .run_valid      (run_valid),
        .evtflg_flgptn  (evtflg_flgptn),
        .task_status    (task_status),
        .mismatch_count (mismatch_count),
        .check_count    (check_count)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // next rising edge with cke high, then 1 ns into the cycle
    task automatic wait_enabled_edge();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!cke && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!cke) begin
            timeout_count++;
            $display("timeout at %0t: no enabled clock edge within %0d cycles",
                     $time, WAIT_LIMIT);
        end
        #1;
    endtask

    task automatic drive_random_command();
        int unsigned roll;
        rtos_cmd_t   c;
        roll     = rand_below(100);
        // wake-ups dominate, all tasks start asleep
        c.op     = (roll < 30) ? OP_WUP_TSK :
                   (roll < 40) ? OP_SLP_TSK :
                   (roll < 50) ? OP_REL_WAI :
                   (roll < 70) ? OP_WAI_FLG :
                   (roll < 85) ? OP_SET_FLG :
                   (roll < 95) ? OP_CLR_FLG : OP_NOP;
        // ids 4 and 5 do not exist
        c.tskid  = TSKID_WIDTH'(rand_below(6));
        c.flgptn = FLGPTN_WIDTH'($random(seed));
        // sparse wait patterns, clears that drop only a few bits
        if (c.op == OP_WAI_FLG) c.flgptn = c.flgptn & FLGPTN_WIDTH'($random(seed));
        if (c.op == OP_CLR_FLG) c.flgptn = c.flgptn | FLGPTN_WIDTH'($random(seed));
        c.wfmode  = rtos_wfmode_t'(rand_below(2));
        cmd       = c;
        cmd_valid = 1'b1;
        wait_enabled_edge();
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    // idle enabled cycles, with one stall of 0 to 3 cycles somewhere inside
    task automatic run_idle_gap();
        int unsigned stall_at;
        int unsigned stall_len;
        stall_at  = rand_below(IDLE_NUM);
        stall_len = rand_below(4);
        for (int k = 0; k < IDLE_NUM; k++) begin
            if (k == stall_at && stall_len != 0) begin
                cke = 1'b0;
                repeat (stall_len) @(posedge clk);
                #1;
                cke = 1'b1;
            end
            wait_enabled_edge();
        end
    endtask

    initial begin
        seed          = 32'h6137;
        timeout_count = 0;
        reset         = 1'b1;
        cke           = 1'b1;
        cmd_valid     = 1'b0;
        cmd           = '0;
        final_check   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // first command also checks the reset state
        for (int step = 0; step < STEP_NUM && timeout_count == 0; step++) begin
            drive_random_command();
            run_idle_gap();
        end
        if (timeout_count == 0) begin
            // compare once more after the last command settled
            final_check = 1'b1;
            wait_enabled_edge();
            final_check = 1'b0;
        end

        $display("checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/rtos_pkg.sv
source/rtos_cmd_decode.sv
source/rtos_task.sv
source/rtos_eventflag.sv
source/rtos_ready_queue.sv
source/rtos_core.sv
test/rtos_checker.sv
test/rtos_core_tb.sv

// ==== Bender.yml ====
package:
  name: rtos_core

sources:
  - source/rtos_pkg.sv
  - source/rtos_cmd_decode.sv
  - source/rtos_task.sv
  - source/rtos_eventflag.sv
  - source/rtos_ready_queue.sv
  - source/rtos_core.sv
  - target: test
    files:
      - test/rtos_checker.sv
      - test/rtos_core_tb.sv
